//--- common/lsu_params.svh
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// Byte address into the 64 KiB data memory
`define LSU_ADDR_W 16

// Each bank holds every other byte
`define BANK_ADDR_W 15
`define BANK_DEPTH 32768

`define LSU_DATA_W 32

`endif

//--- common/lsu_pkg.sv
`default_nettype none

`include "lsu_params.svh"

package lsu_pkg;

	// Access size, lower two bits of funct3
	typedef enum logic [1:0] {
		MEM_BYTE = 2'b00,
		MEM_HALF = 2'b01,
		MEM_WORD = 2'b10,
		MEM_RSVD = 2'b11
	} mem_size_e;

	// One data word, either raw or split into bytes (byte 0 lowest)
	typedef union packed {
		logic [`LSU_DATA_W-1:0]             raw;
		logic [`LSU_DATA_W/8-1:0][7:0]      bytes;
	} lsu_word_u;

endpackage

`default_nettype wire

//--- bank/byte_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module byte_bank #(
	parameter int ADDR_W = `BANK_ADDR_W,
	parameter int DEPTH  = `BANK_DEPTH
) (
	input  logic              i_clk,

	input  logic [ADDR_W-1:0] i_addr_1,
	input  logic [7:0]        i_wdata_1,
	input  logic              i_we_1,

	input  logic [ADDR_W-1:0] i_addr_2,
	input  logic [7:0]        i_wdata_2,
	input  logic              i_we_2,

	output logic [7:0]        o_rdata_1,
	output logic [7:0]        o_rdata_2
);

	logic [7:0] mem [DEPTH];

	// Two ports never hit the same index within one access
	always_ff @(posedge i_clk) begin
		if (i_we_1) begin
			mem[i_addr_1] <= i_wdata_1;
		end
		if (i_we_2) begin
			mem[i_addr_2] <= i_wdata_2;
		end
	end

	// Registered reads see the value from before this edge's write
	always_ff @(posedge i_clk) begin
		o_rdata_1 <= mem[i_addr_1];
		o_rdata_2 <= mem[i_addr_2];
	end

endmodule

`default_nettype wire

//--- verilog/store_bank_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module store_bank_decode (
	input  logic [`LSU_ADDR_W-1:0]  i_addr,
	input  lsu_pkg::mem_size_e      i_size,
	input  logic                    i_wren,
	input  logic [`LSU_DATA_W-1:0]  i_st_data,

	output logic [`BANK_ADDR_W-1:0] o_addr_even_1,
	output logic [`BANK_ADDR_W-1:0] o_addr_even_2,
	output logic [`BANK_ADDR_W-1:0] o_addr_odd_1,
	output logic [`BANK_ADDR_W-1:0] o_addr_odd_2,
	output logic [7:0]              o_data_even_1,
	output logic [7:0]              o_data_even_2,
	output logic [7:0]              o_data_odd_1,
	output logic [7:0]              o_data_odd_2,
	output logic                    o_we_even_1,
	output logic                    o_we_even_2,
	output logic                    o_we_odd_1,
	output logic                    o_we_odd_2
);

	logic [`LSU_ADDR_W-1:0]  addr_b0;
	logic [`LSU_ADDR_W-1:0]  addr_b1;
	logic [`LSU_ADDR_W-1:0]  addr_b2;
	logic [`LSU_ADDR_W-1:0]  addr_b3;
	logic [`BANK_ADDR_W-1:0] idx_b0;
	logic [`BANK_ADDR_W-1:0] idx_b1;
	logic [`BANK_ADDR_W-1:0] idx_b2;
	logic [`BANK_ADDR_W-1:0] idx_b3;
	logic [3:0]              size_mask;
	logic [3:0]              we_b;
	lsu_pkg::lsu_word_u      st_word;

	// Byte addresses A..A+3, wrapping at the top of memory
	assign addr_b0 = i_addr;
	assign addr_b1 = i_addr + 2'd1;
	assign addr_b2 = i_addr + 2'd2;
	assign addr_b3 = i_addr + 2'd3;

	// Index inside the bank drops the parity bit
	assign idx_b0 = addr_b0[`LSU_ADDR_W-1:1];
	assign idx_b1 = addr_b1[`LSU_ADDR_W-1:1];
	assign idx_b2 = addr_b2[`LSU_ADDR_W-1:1];
	assign idx_b3 = addr_b3[`LSU_ADDR_W-1:1];

	// Bytes touched by the access, none for the reserved size
	always_comb begin
		case (i_size)
			lsu_pkg::MEM_BYTE: size_mask = 4'b0001;
			lsu_pkg::MEM_HALF: size_mask = 4'b0011;
			lsu_pkg::MEM_WORD: size_mask = 4'b1111;
			default:           size_mask = 4'b0000;
		endcase
	end

	assign we_b = size_mask & {4{i_wren}};

	always_comb begin
		st_word.raw = i_st_data;
	end

	// Byte k lands in bank k[0]^A[0], port k[1]
	always_comb begin
		if (!i_addr[0]) begin
			o_addr_even_1 = idx_b0;
			o_data_even_1 = st_word.bytes[0];
			o_we_even_1   = we_b[0];

			o_addr_odd_1  = idx_b1;
			o_data_odd_1  = st_word.bytes[1];
			o_we_odd_1    = we_b[1];

			o_addr_even_2 = idx_b2;
			o_data_even_2 = st_word.bytes[2];
			o_we_even_2   = we_b[2];

			o_addr_odd_2  = idx_b3;
			o_data_odd_2  = st_word.bytes[3];
			o_we_odd_2    = we_b[3];
		end else begin
			o_addr_odd_1  = idx_b0;
			o_data_odd_1  = st_word.bytes[0];
			o_we_odd_1    = we_b[0];

			o_addr_even_1 = idx_b1;
			o_data_even_1 = st_word.bytes[1];
			o_we_even_1   = we_b[1];

			o_addr_odd_2  = idx_b2;
			o_data_odd_2  = st_word.bytes[2];
			o_we_odd_2    = we_b[2];

			o_addr_even_2 = idx_b3;
			o_data_even_2 = st_word.bytes[3];
			o_we_even_2   = we_b[3];
		end
	end

endmodule

`default_nettype wire

//--- verilog/load_align.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module load_align (
	input  logic                   i_clk,
	input  logic                   i_rst_n,

	input  logic                   i_ld_req,
	input  logic                   i_addr_lsb,
	input  lsu_pkg::mem_size_e     i_size,
	input  logic                   i_unsigned,

	input  logic [7:0]             i_even_1,
	input  logic [7:0]             i_even_2,
	input  logic [7:0]             i_odd_1,
	input  logic [7:0]             i_odd_2,

	output logic [`LSU_DATA_W-1:0] o_ld_data,
	output logic                   o_ld_valid
);

	logic                   lsb_q;
	lsu_pkg::mem_size_e     size_q;
	logic                   unsigned_q;
	logic                   valid_q;
	lsu_pkg::lsu_word_u     ld_bytes;
	logic [`LSU_DATA_W-1:0] ld_word;
	logic                   sign_bit;

	// Attributes of the load whose bytes arrive next cycle
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			valid_q    <= 1'b0;
			lsb_q      <= 1'b0;
			size_q     <= lsu_pkg::MEM_BYTE;
			unsigned_q <= 1'b0;
		end else begin
			valid_q <= i_ld_req;
			if (i_ld_req) begin
				lsb_q      <= i_addr_lsb;
				size_q     <= i_size;
				unsigned_q <= i_unsigned;
			end
		end
	end

	// Undo the bank/port interleave of the decoder
	always_comb begin
		if (!lsb_q) begin
			ld_bytes.bytes[0] = i_even_1;
			ld_bytes.bytes[1] = i_odd_1;
			ld_bytes.bytes[2] = i_even_2;
			ld_bytes.bytes[3] = i_odd_2;
		end else begin
			ld_bytes.bytes[0] = i_odd_1;
			ld_bytes.bytes[1] = i_even_1;
			ld_bytes.bytes[2] = i_odd_2;
			ld_bytes.bytes[3] = i_even_2;
		end
	end

	always_comb begin
		sign_bit = 1'b0;
		case (size_q)
			lsu_pkg::MEM_BYTE: begin
				sign_bit = ~unsigned_q & ld_bytes.bytes[0][7];
				ld_word  = {{24{sign_bit}}, ld_bytes.bytes[0]};
			end
			lsu_pkg::MEM_HALF: begin
				sign_bit = ~unsigned_q & ld_bytes.bytes[1][7];
				ld_word  = {{16{sign_bit}}, ld_bytes.bytes[1], ld_bytes.bytes[0]};
			end
			lsu_pkg::MEM_WORD: begin
				ld_word = ld_bytes.raw;
			end
			default: begin
				ld_word = '0;
			end
		endcase
	end

	assign o_ld_data  = ld_word;
	assign o_ld_valid = valid_q;

endmodule

`default_nettype wire

//--- verilog/lsu_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module lsu_mem (
	input  logic                   i_clk,
	input  logic                   i_rst_n,

	input  logic [`LSU_ADDR_W-1:0] i_addr,
	input  lsu_pkg::mem_size_e     i_size,
	input  logic                   i_unsigned,
	input  logic                   i_wren,
	input  logic [`LSU_DATA_W-1:0] i_st_data,
	input  logic                   i_ld_req,

	output logic [`LSU_DATA_W-1:0] o_ld_data,
	output logic                   o_ld_valid
);

	logic [`BANK_ADDR_W-1:0] addr_even_1;
	logic [`BANK_ADDR_W-1:0] addr_even_2;
	logic [`BANK_ADDR_W-1:0] addr_odd_1;
	logic [`BANK_ADDR_W-1:0] addr_odd_2;
	logic [7:0]              wdata_even_1;
	logic [7:0]              wdata_even_2;
	logic [7:0]              wdata_odd_1;
	logic [7:0]              wdata_odd_2;
	logic                    we_even_1;
	logic                    we_even_2;
	logic                    we_odd_1;
	logic                    we_odd_2;
	logic [7:0]              rdata_even_1;
	logic [7:0]              rdata_even_2;
	logic [7:0]              rdata_odd_1;
	logic [7:0]              rdata_odd_2;

	store_bank_decode u_decode (
		.i_addr        (i_addr),
		.i_size        (i_size),
		.i_wren        (i_wren),
		.i_st_data     (i_st_data),
		.o_addr_even_1 (addr_even_1),
		.o_addr_even_2 (addr_even_2),
		.o_addr_odd_1  (addr_odd_1),
		.o_addr_odd_2  (addr_odd_2),
		.o_data_even_1 (wdata_even_1),
		.o_data_even_2 (wdata_even_2),
		.o_data_odd_1  (wdata_odd_1),
		.o_data_odd_2  (wdata_odd_2),
		.o_we_even_1   (we_even_1),
		.o_we_even_2   (we_even_2),
		.o_we_odd_1    (we_odd_1),
		.o_we_odd_2    (we_odd_2)
	);

	byte_bank u_bank_even (
		.i_clk     (i_clk),
		.i_addr_1  (addr_even_1),
		.i_wdata_1 (wdata_even_1),
		.i_we_1    (we_even_1),
		.i_addr_2  (addr_even_2),
		.i_wdata_2 (wdata_even_2),
		.i_we_2    (we_even_2),
		.o_rdata_1 (rdata_even_1),
		.o_rdata_2 (rdata_even_2)
	);

	byte_bank u_bank_odd (
		.i_clk     (i_clk),
		.i_addr_1  (addr_odd_1),
		.i_wdata_1 (wdata_odd_1),
		.i_we_1    (we_odd_1),
		.i_addr_2  (addr_odd_2),
		.i_wdata_2 (wdata_odd_2),
		.i_we_2    (we_odd_2),
		.o_rdata_1 (rdata_odd_1),
		.o_rdata_2 (rdata_odd_2)
	);

	// Start parity decides how the aligner undoes the interleave
	load_align u_align (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_ld_req   (i_ld_req),
		.i_addr_lsb (i_addr[0]),
		.i_size     (i_size),
		.i_unsigned (i_unsigned),
		.i_even_1   (rdata_even_1),
		.i_even_2   (rdata_even_2),
		.i_odd_1    (rdata_odd_1),
		.i_odd_2    (rdata_odd_2),
		.o_ld_data  (o_ld_data),
		.o_ld_valid (o_ld_valid)
	);

endmodule

`default_nettype wire

//--- tests/lsu_mem_sva.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_mem_sva (
	input logic i_clk,
	input logic i_rst_n,
	input logic i_wren,
	input logic i_ld_req,
	input logic i_ld_valid,
	input logic i_we_even_1,
	input logic i_we_even_2,
	input logic i_we_odd_1,
	input logic i_we_odd_2
);

	int unsigned n_fail = 0;
	logic        we_any;

	assign we_any = i_we_even_1 | i_we_even_2 | i_we_odd_1 | i_we_odd_2;

	a_valid_timing: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_ld_valid == $past(i_ld_req))
	else begin
		n_fail++;
		$error("load valid is not the load request delayed by one cycle");
	end

	// Write enables only ever come from a store strobe
	a_we_needs_wren: assert property (@(posedge i_clk) we_any |-> i_wren)
	else begin
		n_fail++;
		$error("bank write enable high without a store strobe");
	end

	a_one_request: assert property (@(posedge i_clk) !(i_wren && i_ld_req))
	else begin
		n_fail++;
		$error("store and load strobes high in the same cycle");
	end

	a_reset_quiet: assert property (@(posedge i_clk) $past(!i_rst_n) |-> !i_ld_valid)
	else begin
		n_fail++;
		$error("load valid high right after a reset cycle");
	end

endmodule

`default_nettype wire

//--- tests/lsu_mem_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module lsu_mem_tb;

	localparam int    RESET_CYCLES = 16;
	localparam string VEC_FILE     = "tests/lsu_vectors.txt";

	logic                   i_clk;
	logic                   i_rst_n;
	logic [`LSU_ADDR_W-1:0] i_addr;
	lsu_pkg::mem_size_e     i_size;
	logic                   i_unsigned;
	logic                   i_wren;
	logic [`LSU_DATA_W-1:0] i_st_data;
	logic                   i_ld_req;
	logic [`LSU_DATA_W-1:0] o_ld_data;
	logic                   o_ld_valid;

	string                  v_name[$];
	string                  v_op[$];
	logic [`LSU_ADDR_W-1:0] v_addr[$];
	logic [1:0]             v_size[$];
	logic                   v_uns[$];
	logic [`LSU_DATA_W-1:0] v_data[$];
	lsu_pkg::lsu_word_u     v_want[$];
	// Loads in flight, oldest first
	string                  q_name[$];
	lsu_pkg::lsu_word_u     q_want[$];
	int                     n_pass = 0;
	int                     n_fail = 0;
	int                     n_err = 0;
	logic                   req_prev = 1'b0;
	logic                   vec_ready = 1'b0;

	lsu_mem dut (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_addr     (i_addr),
		.i_size     (i_size),
		.i_unsigned (i_unsigned),
		.i_wren     (i_wren),
		.i_st_data  (i_st_data),
		.i_ld_req   (i_ld_req),
		.o_ld_data  (o_ld_data),
		.o_ld_valid (o_ld_valid)
	);

	bind lsu_mem lsu_mem_sva u_sva (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_wren      (i_wren),
		.i_ld_req    (i_ld_req),
		.i_ld_valid  (o_ld_valid),
		.i_we_even_1 (we_even_1),
		.i_we_even_2 (we_even_2),
		.i_we_odd_1  (we_odd_1),
		.i_we_odd_2  (we_odd_2)
	);

	always #4 i_clk = ~i_clk;

	task automatic read_vectors();
		int                     fd;
		int                     n;
		string                  line;
		string                  name;
		string                  op;
		logic [`LSU_ADDR_W-1:0] addr;
		int                     size;
		int                     uns;
		logic [`LSU_DATA_W-1:0] data;
		logic [`LSU_DATA_W-1:0] want;
		fd = $fopen(VEC_FILE, "r");
		if (fd == 0) begin
			$display("Cannot open the vector file %s", VEC_FILE);
			n_err++;
			return;
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() == 0 || line.getc(0) == "#") begin
				continue;
			end
			n = $sscanf(line, "%s %s %h %d %d %h %h", name, op, addr, size, uns, data, want);
			if (n == 7) begin
				v_name.push_back(name);
				v_op.push_back(op);
				v_addr.push_back(addr);
				v_size.push_back(size[1:0]);
				v_uns.push_back(uns[0]);
				v_data.push_back(data);
				v_want.push_back(want);
			end else if (n > 0) begin
				$display("Vector line could not be parsed: %s", line);
				n_err++;
			end
		end
		$fclose(fd);
	endtask

	task automatic check_word(input string name, input lsu_pkg::lsu_word_u want,
			input lsu_pkg::lsu_word_u got);
		if (got.raw === want.raw) begin
			n_pass++;
			$display("[PASS] %s %08h", name, got.raw);
		end else begin
			n_fail++;
			$display("[FAIL] %s expected %08h actual %08h", name, want.raw, got.raw);
		end
	endtask

	task automatic check_valid(input logic want, input logic got);
		if (want && !got) begin
			$display("Load valid pulse missing one cycle after a load request");
			n_err++;
		end else if (!want && got) begin
			$display("Load valid pulse seen without a load request");
			n_err++;
		end
	endtask

	task automatic drive_vector(input int i);
		@(posedge i_clk);
		i_addr     <= v_addr[i];
		i_size     <= lsu_pkg::mem_size_e'(v_size[i]);
		i_unsigned <= v_uns[i];
		i_st_data  <= v_data[i];
		if (v_op[i] == "store") begin
			i_wren   <= 1'b1;
			i_ld_req <= 1'b0;
		end else if (v_op[i] == "load" || v_op[i] == "loadbb") begin
			i_wren   <= 1'b0;
			i_ld_req <= 1'b1;
			q_name.push_back(v_name[i]);
			q_want.push_back(v_want[i]);
		end else begin
			$display("Unknown operation %s in vector %s", v_op[i], v_name[i]);
			n_err++;
			i_wren   <= 1'b0;
			i_ld_req <= 1'b0;
		end
	endtask

	task automatic wait_result(input string name);
		int cycles;
		@(posedge i_clk);
		i_wren   <= 1'b0;
		i_ld_req <= 1'b0;
		cycles = 0;
		while (q_want.size() != 0 && cycles < 4) begin
			@(posedge i_clk);
			cycles++;
		end
		if (q_want.size() != 0) begin
			$display("No load result came back for %s", name);
			n_err++;
			q_name.delete();
			q_want.delete();
		end
	endtask

	// Outputs settle after the rising edge, so look at them on the falling one
	always @(negedge i_clk) begin
		check_valid(req_prev, o_ld_valid);
		if (o_ld_valid && q_want.size() != 0) begin
			check_word(q_name.pop_front(), q_want.pop_front(), o_ld_data);
		end
		req_prev = i_ld_req;
	end

	initial begin
		wait (vec_ready);
		repeat (v_name.size() * 10 + RESET_CYCLES) @(posedge i_clk);
		$display("Watchdog expired, the run did not finish in time");
		$display("Finished with errors");
		$finish;
	end

	initial begin
		i_clk      = 1'b0;
		i_rst_n    = 1'b0;
		i_addr     = '0;
		i_size     = lsu_pkg::MEM_BYTE;
		i_unsigned = 1'b0;
		i_wren     = 1'b0;
		i_st_data  = '0;
		i_ld_req   = 1'b0;
		read_vectors();
		if (v_name.size() == 0) begin
			$display("No vectors were read");
			n_err++;
		end
		vec_ready = 1'b1;
		repeat (RESET_CYCLES) @(posedge i_clk);
		i_rst_n <= 1'b1;
		for (int i = 0; i < v_name.size(); i++) begin
			drive_vector(i);
			if (v_op[i] == "load") begin
				wait_result(v_name[i]);
			end
		end
		wait_result("final drain");
		repeat (2) @(posedge i_clk);
		$display("Loads passed %0d, failed %0d, other errors %0d, assertion failures %0d",
			n_pass, n_fail, n_err, dut.u_sva.n_fail);
		if (n_fail == 0 && n_err == 0 && dut.u_sva.n_fail == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tests/lsu_vectors.txt
# name op addr size unsigned data expected (size 0 byte, 1 half, 2 word, 3 reserved)
# addr, data and expected in hex; loads ignore data, stores ignore expected
st_w0       store  0100 2 0 11223344 00000000
ld_w0       load   0100 2 0 00000000 11223344
st_h0       store  0200 1 0 0000a5b6 00000000
ld_h0_s     load   0200 1 0 00000000 ffffa5b6
ld_h0_u     load   0200 1 1 00000000 0000a5b6
st_b0       store  0300 0 0 00000081 00000000
ld_b0_s     load   0300 0 0 00000000 ffffff81
ld_b0_u     load   0300 0 1 00000000 00000081
st_w1       store  0401 2 0 deadbeef 00000000
ld_w1       load   0401 2 0 00000000 deadbeef
ld_w1_b0    load   0401 0 1 00000000 000000ef
ld_w1_b1    load   0402 0 1 00000000 000000be
ld_w1_b2    load   0403 0 1 00000000 000000ad
ld_w1_b3    load   0404 0 1 00000000 000000de
st_w2       store  0502 2 0 cafef00d 00000000
ld_w2       load   0502 2 0 00000000 cafef00d
ld_w2_h1    load   0503 1 1 00000000 0000fef0
st_h1       store  0603 1 0 00001234 00000000
ld_h1       load   0603 1 0 00000000 00001234
st_w3       store  0700 2 0 01020304 00000000
st_b2       store  0702 0 0 000000aa 00000000
ld_w3       load   0700 2 0 00000000 01aa0304
st_wrap     store  ffff 2 0 55667788 00000000
ld_wrap     load   ffff 2 0 00000000 55667788
ld_wrap_h   load   0000 1 1 00000000 00006677
st_rsvd     store  0100 3 0 ffffffff 00000000
ld_w0_again load   0100 2 0 00000000 11223344
ld_rsvd     load   0100 3 0 00000000 00000000
bb0         loadbb 0100 2 0 00000000 11223344
bb1         loadbb 0401 2 0 00000000 deadbeef
bb2         load   0300 0 0 00000000 ffffff81

//--- list.f
+incdir+common
common/lsu_pkg.sv
bank/byte_bank.sv
verilog/store_bank_decode.sv
verilog/load_align.sv
verilog/lsu_mem.sv
tests/lsu_mem_sva.sv
tests/lsu_mem_tb.sv

//--- Makefile
TOP = lsu_mem_tb

.PHONY: simulate clean

simulate:
	verilator --binary --timing --assert -f list.f --top-module $(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee /dev/stderr | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir
